// File: pce_ctrl_pkg.sv
`default_nettype none

package pce_ctrl_pkg;

	// ========================================================================
	// Pad and multitap sizes
	// ========================================================================

	localparam int PAD_BITS      = 12; // Buttons III..VI, run..I, directions
	localparam int PORT_IDX_BITS = 3;

	// Multitap has ports 0..4, index 5 reads as an empty port
	localparam logic [PORT_IDX_BITS-1:0] TAP_PORTS = 3'd5;

	// CLR low this long restarts the mouse sequence
	localparam logic [14:0] MOUSE_IDLE_CYCLES = 15'd32767;

	localparam logic [15:0] NO_PAD_WORD = 16'h0FFF; // All buttons released, id 0

	// ========================================================================
	// Port word, active low, one nibble per CLR/SEL/bank combination
	// ========================================================================

	typedef union packed {
		struct packed {
			logic [3:0] id;          // Always 0 for a pad
			logic [3:0] ext_buttons; // VI, V, IV, III
			logic [3:0] dirs;        // Left, down, right, up
			logic [3:0] buttons;     // Run, select, II, I
		} pad;
		logic [3:0][3:0] nib;        // Nibble 0 is the button nibble
	} port_word_t;

endpackage

`default_nettype wire

// File: tap_scan_fsm.sv
`default_nettype none

module tap_scan_fsm (
	input  logic                                  clk_sys,
	input  logic                                  arst_n,
	input  logic                                  pad_clr,
	input  logic                                  pad_sel,
	input  logic                                  turbotap,
	input  logic                                  buttons6,
	output logic                                  clr_rise,
	output logic [pce_ctrl_pkg::PORT_IDX_BITS-1:0] port_idx,
	output logic                                  high_bank
);

	logic clr_q; // Previous CLR level
	logic sel_q; // Previous SEL level
	logic sel_rise;

	assign clr_rise = pad_clr & ~clr_q;
	assign sel_rise = pad_sel & ~sel_q;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			clr_q <= 1'b0;
			sel_q <= 1'b0;
		end else begin
			clr_q <= pad_clr;
			sel_q <= pad_sel;
		end
	end

	// ========================================================================
	// Port index and button bank
	// ========================================================================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			port_idx  <= '0;
			high_bank <= 1'b0;
		end else if (pad_clr) begin
			port_idx <= '0; // CLR restarts the multitap scan
			if (clr_rise)
				high_bank <= ~high_bank & buttons6; // Six-button pads flip bank per frame
		end else if (sel_rise && turbotap && port_idx < pce_ctrl_pkg::TAP_PORTS) begin
			port_idx <= port_idx + 1'b1; // Stops on the empty port
		end
	end

	a_port_idx_range: assert property (@(posedge clk_sys) disable iff (!arst_n)
		port_idx <= pce_ctrl_pkg::TAP_PORTS)
		else $error("port_idx beyond last multitap port");

	a_clr_rise_single: assert property (@(posedge clk_sys) disable iff (!arst_n)
		clr_rise |=> !clr_rise)
		else $error("clr_rise held for more than one cycle");

endmodule

`default_nettype wire

// File: mouse_phase_counter.sv
`default_nettype none

module mouse_phase_counter (
	input  logic       clk_sys,
	input  logic       arst_n,
	input  logic       pad_clr,
	input  logic       clr_rise,
	output logic [1:0] mouse_phase,
	output logic       frame_end
);

	logic [14:0] idle_cnt; // Cycles spent with CLR low
	logic        idle_done;

	assign idle_done = (idle_cnt == pce_ctrl_pkg::MOUSE_IDLE_CYCLES);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			idle_cnt <= '0;
		else if (pad_clr)
			idle_cnt <= '0;
		else if (!idle_done)
			idle_cnt <= idle_cnt + 1'b1; // Saturates at the idle limit
	end

	// ========================================================================
	// Nibble phase, one step per CLR pulse
	// ========================================================================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			mouse_phase <= 2'd3;
		else if (clr_rise)
			mouse_phase <= mouse_phase + 1'b1;
		else if (idle_done)
			mouse_phase <= 2'd3; // Next pulse starts over at X high nibble
	end

	assign frame_end = clr_rise & (mouse_phase == 2'd3);

	// A frame closes on a CLR pulse and always reopens at phase 0
	a_frame_end_wrap: assert property (@(posedge clk_sys) disable iff (!arst_n)
		frame_end |-> clr_rise ##1 (mouse_phase == 2'd0))
		else $error("frame_end without clr_rise or phase wrap");

endmodule

`default_nettype wire

// File: mouse_delta.sv
`default_nettype none

module mouse_delta (
	input  logic       clk_sys,
	input  logic       arst_n,
	input  logic [7:0] mouse_x,
	input  logic [7:0] mouse_y,
	input  logic       mouse_strobe,
	input  logic [1:0] mouse_btn,
	input  logic [1:0] pad0_run_sel,
	input  logic [1:0] mouse_phase,
	input  logic       frame_end,
	output logic [7:0] mouse_byte
);

	logic [7:0] pend_x; // Collected since the last frame
	logic [7:0] pend_y;
	logic [7:0] held_x; // Reported during the current frame
	logic [7:0] held_y;

	// ========================================================================
	// Pending and held movement
	// ========================================================================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			pend_x <= '0;
			pend_y <= '0;
			held_x <= '0;
			held_y <= '0;
		end else begin
			if (frame_end) begin
				held_x <= pend_x;
				held_y <= pend_y;
				pend_x <= '0;
				pend_y <= '0;
			end
			// New movement overrides the clear above
			if (mouse_strobe) begin
				pend_x <= 8'd0 - mouse_x; // Console expects X reversed
				pend_y <= mouse_y;
			end
		end
	end

	// ========================================================================
	// Nibble-serial byte
	// ========================================================================

	always_comb begin
		case (mouse_phase)
			2'd0:    mouse_byte[7:4] = held_x[7:4];
			2'd1:    mouse_byte[7:4] = held_x[3:0];
			2'd2:    mouse_byte[7:4] = held_y[7:4];
			default: mouse_byte[7:4] = held_y[3:0];
		endcase
	end

	assign mouse_byte[3:0] = ~{pad0_run_sel, mouse_btn[0], mouse_btn[1]}; // Active low

endmodule

`default_nettype wire

// File: pad_port_mux.sv
`default_nettype none

module pad_port_mux (
	input  logic                                  clk_sys,
	input  logic                                  arst_n,
	input  logic [pce_ctrl_pkg::PAD_BITS-1:0]      joy_a,
	input  logic [pce_ctrl_pkg::PAD_BITS-1:0]      joy_b,
	input  logic [pce_ctrl_pkg::PAD_BITS-1:0]      joy_2,
	input  logic [pce_ctrl_pkg::PAD_BITS-1:0]      joy_3,
	input  logic [pce_ctrl_pkg::PAD_BITS-1:0]      joy_4,
	input  logic                                  joy_swap,
	input  logic                                  mouse_en,
	input  logic [7:0]                            mouse_byte,
	input  logic [pce_ctrl_pkg::PORT_IDX_BITS-1:0] port_idx,
	input  logic                                  high_bank,
	input  logic                                  pad_sel,
	input  logic                                  pad_clr,
	output logic [3:0]                            pad_nibble,
	output logic [1:0]                            pad0_run_sel
);

	logic [pce_ctrl_pkg::PAD_BITS-1:0] pad_0; // After the swap
	logic [pce_ctrl_pkg::PAD_BITS-1:0] pad_1;
	logic [pce_ctrl_pkg::PAD_BITS-1:0] pad_cur;
	pce_ctrl_pkg::port_word_t          word;

	assign pad_0 = joy_swap ? joy_b : joy_a;
	assign pad_1 = joy_swap ? joy_a : joy_b;

	assign pad0_run_sel = pad_0[7:6]; // Run and select for the mouse byte

	// ========================================================================
	// Port selection
	// ========================================================================

	always_comb begin
		case (port_idx)
			3'd1:    pad_cur = pad_1;
			3'd2:    pad_cur = joy_2;
			3'd3:    pad_cur = joy_3;
			3'd4:    pad_cur = joy_4;
			default: pad_cur = pad_0;
		endcase
	end

	always_comb begin
		word.pad.id          = 4'h0;
		word.pad.ext_buttons = ~pad_cur[11:8];
		word.pad.dirs        = ~{pad_cur[1], pad_cur[2], pad_cur[0], pad_cur[3]}; // L D R U
		word.pad.buttons     = ~pad_cur[7:4];
		if (port_idx == '0 && mouse_en)
			word = pce_ctrl_pkg::port_word_t'({mouse_byte, mouse_byte});
		else if (port_idx >= pce_ctrl_pkg::TAP_PORTS)
			word = pce_ctrl_pkg::port_word_t'(pce_ctrl_pkg::NO_PAD_WORD);
	end

	// ========================================================================
	// Output latch
	// ========================================================================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			pad_nibble <= 4'h0;
		else if (pad_clr)
			pad_nibble <= 4'h0;
		else
			pad_nibble <= word.nib[{high_bank, pad_sel}];
	end

	a_clr_clears_nibble: assert property (@(posedge clk_sys) disable iff (!arst_n)
		pad_clr |=> (pad_nibble == 4'h0))
		else $error("pad_nibble not cleared after CLR");

endmodule

`default_nettype wire

// File: pce_ctrl_port.sv
`default_nettype none

module pce_ctrl_port (
	input  logic                             clk_sys,
	input  logic                             arst_n,
	input  logic                             pad_clr,
	input  logic                             pad_sel,
	input  logic [pce_ctrl_pkg::PAD_BITS-1:0] joy_a,
	input  logic [pce_ctrl_pkg::PAD_BITS-1:0] joy_b,
	input  logic [pce_ctrl_pkg::PAD_BITS-1:0] joy_2,
	input  logic [pce_ctrl_pkg::PAD_BITS-1:0] joy_3,
	input  logic [pce_ctrl_pkg::PAD_BITS-1:0] joy_4,
	input  logic                             joy_swap,
	input  logic                             turbotap,
	input  logic                             buttons6,
	input  logic                             mouse_en,
	input  logic [7:0]                       mouse_x,
	input  logic [7:0]                       mouse_y,
	input  logic [1:0]                       mouse_btn,
	input  logic                             mouse_strobe,
	output logic [3:0]                       joy_in
);

	logic                                  clr_rise;
	logic [pce_ctrl_pkg::PORT_IDX_BITS-1:0] port_idx;
	logic                                  high_bank;
	logic [1:0]                            mouse_phase;
	logic                                  frame_end;
	logic [7:0]                            mouse_byte;
	logic [1:0]                            pad0_run_sel;

	tap_scan_fsm i_tap_scan_fsm (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.pad_clr   (pad_clr),
		.pad_sel   (pad_sel),
		.turbotap  (turbotap),
		.buttons6  (buttons6),
		.clr_rise  (clr_rise),
		.port_idx  (port_idx),
		.high_bank (high_bank)
	);

	mouse_phase_counter i_mouse_phase_counter (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.pad_clr     (pad_clr),
		.clr_rise    (clr_rise),
		.mouse_phase (mouse_phase),
		.frame_end   (frame_end)
	);

	mouse_delta i_mouse_delta (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.mouse_x      (mouse_x),
		.mouse_y      (mouse_y),
		.mouse_strobe (mouse_strobe),
		.mouse_btn    (mouse_btn),
		.pad0_run_sel (pad0_run_sel),
		.mouse_phase  (mouse_phase),
		.frame_end    (frame_end),
		.mouse_byte   (mouse_byte)
	);

	pad_port_mux i_pad_port_mux (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.joy_a        (joy_a),
		.joy_b        (joy_b),
		.joy_2        (joy_2),
		.joy_3        (joy_3),
		.joy_4        (joy_4),
		.joy_swap     (joy_swap),
		.mouse_en     (mouse_en),
		.mouse_byte   (mouse_byte),
		.port_idx     (port_idx),
		.high_bank    (high_bank),
		.pad_sel      (pad_sel),
		.pad_clr      (pad_clr),
		.pad_nibble   (joy_in),
		.pad0_run_sel (pad0_run_sel)
	);

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
	output logic clk_sys
);

	localparam int HALF_PERIOD = 2; // 4-unit period

	initial clk_sys = 1'b0;

	always #HALF_PERIOD clk_sys = ~clk_sys;

endmodule

`default_nettype wire

// File: tb_pce_ctrl_port.sv
`default_nettype none

module tb_pce_ctrl_port;

	// Idle wait of about 32800 cycles plus the pad and mouse tests
	localparam int TIMEOUT_CYCLES = 40000;

	logic        clk_sys;
	logic        arst_n;
	logic        pad_clr;
	logic        pad_sel;
	logic [11:0] joy_a;
	logic [11:0] joy_b;
	logic [11:0] joy_2;
	logic [11:0] joy_3;
	logic [11:0] joy_4;
	logic        joy_swap;
	logic        turbotap;
	logic        buttons6;
	logic        mouse_en;
	logic [7:0]  mouse_x;
	logic [7:0]  mouse_y;
	logic [1:0]  mouse_btn;
	logic        mouse_strobe;
	logic [3:0]  joy_in;

	integer seed = 32'h03370a16;
	int     cycles;
	int     cmp_wait;
	int     test_count;
	int     check_count;
	int     error_count;
	int     test_err_base;

	// Model of the port state
	logic [2:0] m_idx;
	logic       m_bank;
	logic [1:0] m_phase;
	logic [7:0] m_pend_x;
	logic [7:0] m_pend_y;
	logic [7:0] m_held_x;
	logic [7:0] m_held_y;
	logic       m_clr_q;
	logic       m_sel_q;

	tb_clock_gen i_tb_clock_gen (.clk_sys(clk_sys));

	pce_ctrl_port i_pce_ctrl_port (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.pad_clr      (pad_clr),
		.pad_sel      (pad_sel),
		.joy_a        (joy_a),
		.joy_b        (joy_b),
		.joy_2        (joy_2),
		.joy_3        (joy_3),
		.joy_4        (joy_4),
		.joy_swap     (joy_swap),
		.turbotap     (turbotap),
		.buttons6     (buttons6),
		.mouse_en     (mouse_en),
		.mouse_x      (mouse_x),
		.mouse_y      (mouse_y),
		.mouse_btn    (mouse_btn),
		.mouse_strobe (mouse_strobe),
		.joy_in       (joy_in)
	);

	// ========================================================================
	// Expected nibble and compare
	// ========================================================================

	function automatic logic [3:0] expected_nibble(input logic clr, input logic sel,
			input logic [2:0] idx, input logic bank, input logic [1:0] phase,
			input logic [7:0] hx, input logic [7:0] hy);
		pce_ctrl_pkg::port_word_t w;
		logic [11:0] p;
		logic [3:0]  mhi;
		case (idx)
			3'd0:    p = joy_swap ? joy_b : joy_a;
			3'd1:    p = joy_swap ? joy_a : joy_b;
			3'd2:    p = joy_2;
			3'd3:    p = joy_3;
			default: p = joy_4;
		endcase
		mhi = (phase == 2'd0) ? hx[7:4] : (phase == 2'd1) ? hx[3:0] :
			(phase == 2'd2) ? hy[7:4] : hy[3:0];
		w.pad.id          = 4'h0;
		w.pad.ext_buttons = ~p[11:8];
		w.pad.dirs        = ~{p[1], p[2], p[0], p[3]}; // Left, down, right, up
		w.pad.buttons     = ~p[7:4];
		if (idx >= 3'd5)
			w = pce_ctrl_pkg::port_word_t'(pce_ctrl_pkg::NO_PAD_WORD);
		else if (idx == 3'd0 && mouse_en)
			w = pce_ctrl_pkg::port_word_t'({2{mhi, ~{p[7], p[6], mouse_btn[0], mouse_btn[1]}}});
		return clr ? 4'h0 : w.nib[{bank, sel}];
	endfunction

	task automatic check_value(input string name, input logic [3:0] expected,
			input logic [3:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	always @(posedge clk_sys) begin
		if (cmp_wait != 0) begin
			if (cmp_wait == 1)
				check_value("joy_in", expected_nibble(pad_clr, pad_sel, m_idx, m_bank, m_phase,
					m_held_x, m_held_y), joy_in);
			cmp_wait <= cmp_wait - 1;
		end
	end

	// ========================================================================
	// Stimulus
	// ========================================================================

	task automatic update_model(input logic clr, input logic sel);
		if (clr && !m_clr_q) begin
			m_bank = buttons6 ? ~m_bank : 1'b0;
			if (m_phase == 2'd3) begin // Frame end
				m_held_x = m_pend_x;
				m_held_y = m_pend_y;
				m_pend_x = 8'h00;
				m_pend_y = 8'h00;
			end
			m_phase = m_phase + 2'd1;
		end
		if (clr)
			m_idx = 3'd0;
		else if (sel && !m_sel_q && turbotap && m_idx < 3'd5)
			m_idx = m_idx + 3'd1;
		m_clr_q = clr;
		m_sel_q = sel;
	endtask

	// Drives CLR and SEL, then lets the compare process check joy_in
	task automatic step(input logic clr, input logic sel);
		@(posedge clk_sys);
		pad_clr  <= clr;
		pad_sel  <= sel;
		cmp_wait <= 3;
		update_model(clr, sel);
		repeat (4) @(posedge clk_sys);
	endtask

	task automatic pad_cycle;
		step(1'b1, 1'b0);
		step(1'b0, 1'b0);
		step(1'b0, 1'b1);
	endtask

	task automatic set_options(input logic swap, input logic tap, input logic b6,
			input logic men);
		@(posedge clk_sys);
		joy_swap <= swap;
		turbotap <= tap;
		buttons6 <= b6;
		mouse_en <= men;
	endtask

	task automatic randomize_pads;
		@(posedge clk_sys);
		joy_a <= $random(seed);
		joy_b <= $random(seed);
		joy_2 <= $random(seed);
		joy_3 <= $random(seed);
		joy_4 <= $random(seed);
	endtask

	task automatic strobe_mouse;
		logic [7:0] x;
		logic [7:0] y;
		@(posedge clk_sys);
		x = $random(seed);
		y = $random(seed);
		mouse_x      <= x;
		mouse_y      <= y;
		mouse_btn    <= $random(seed);
		mouse_strobe <= 1'b1;
		m_pend_x = 8'd0 - x; // X reported reversed
		m_pend_y = y;
		@(posedge clk_sys);
		mouse_strobe <= 1'b0;
	endtask

	task automatic wait_idle;
		repeat (int'(pce_ctrl_pkg::MOUSE_IDLE_CYCLES) + 8) @(posedge clk_sys);
		m_phase = 2'd3; // Idle timer forced the last phase
	endtask

	task automatic end_test(input string name);
		test_count++;
		$display("%-12s %0d errors", name, error_count - test_err_base);
		test_err_base = error_count;
	endtask

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk_sys);
			cycles = cycles + 1;
		end
		$display("Timeout: run stopped after %0d cycles", cycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		arst_n <= 1'b0;
		{pad_clr, pad_sel, joy_swap, turbotap, buttons6, mouse_en, mouse_strobe} <= '0;
		{joy_a, joy_b, joy_2, joy_3, joy_4} <= '0;
		{mouse_x, mouse_y, mouse_btn} <= '0;
		{cmp_wait, test_count, check_count, error_count, test_err_base} = '0;
		{m_idx, m_bank, m_pend_x, m_pend_y, m_held_x, m_held_y, m_clr_q, m_sel_q} = '0;
		m_phase = 2'd3;
		repeat (4) @(posedge clk_sys);
		arst_n <= 1'b1;

		set_options(1'b0, 1'b0, 1'b0, 1'b0);
		repeat (8) begin
			randomize_pads();
			pad_cycle();
		end
		end_test("single pad");

		set_options(1'b1, 1'b0, 1'b0, 1'b0);
		repeat (4) begin
			randomize_pads();
			pad_cycle();
		end
		end_test("swap");

		set_options(1'b0, 1'b1, 1'b0, 1'b0);
		repeat (3) begin
			randomize_pads();
			step(1'b1, 1'b0);
			step(1'b0, 1'b0);
			repeat (8) begin // Enough SEL edges to expose an index that wraps
				step(1'b0, 1'b1);
				step(1'b0, 1'b0);
			end
		end
		end_test("multitap");

		set_options(1'b0, 1'b0, 1'b1, 1'b0);
		repeat (5) begin // Odd count leaves the extra bank selected
			randomize_pads();
			pad_cycle();
		end
		set_options(1'b0, 1'b0, 1'b0, 1'b0);
		repeat (4) begin
			randomize_pads();
			pad_cycle();
		end
		end_test("six button");

		set_options(1'b0, 1'b0, 1'b0, 1'b1);
		repeat (2) begin
			strobe_mouse();
			repeat (8) pad_cycle();
		end
		end_test("mouse");

		pad_cycle(); // Leave the phase away from 3
		strobe_mouse();
		wait_idle();
		repeat (4) pad_cycle();
		end_test("mouse idle");

		$display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
		if (error_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
pce_ctrl_pkg.sv
tap_scan_fsm.sv
mouse_phase_counter.sv
mouse_delta.sv
pad_port_mux.sv
pce_ctrl_port.sv
tb_clock_gen.sv
tb_pce_ctrl_port.sv

// File: Bender.yml
package:
  name: pce_ctrl_port

sources:
  - pce_ctrl_pkg.sv
  - tap_scan_fsm.sv
  - mouse_phase_counter.sv
  - mouse_delta.sv
  - pad_port_mux.sv
  - pce_ctrl_port.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_pce_ctrl_port.sv
